/* bench/adc_capture_testdata.txt */
// one hex value per token, read in order; first token is the number of tests
// per test: settings, late settings, rec_length, frame count, write count,
// then frames (lane 7 .. lane 0, 12 bits each), then address and data per write
6
// test 1 divisor 0, unpacked, every frame written
00000001 00000001 4 4 4
fff8007a50c3123456789abc
001002003004005006007008
111222333444555666777888
a0ab0bc0cd0de0ef0f101202
0 0fff080007a500c30123045607890abc
1 00010002000300040005000600070008
2 01110222033304440555066607770888
3 0a0a0b0b0c0c0d0d0e0e0f0f01010202
// test 2 divisor 2, keep last of three
00000004 00000004 2 6 2
100200300400500600700800
010020030040050060070080
00a00b00c00d00e00f010011
123123123123123123123123
321321321321321321321321
fedcba9876543210fedcba98
0 000a000b000c000d000e000f00100011
1 0fed0cba09870654032100fe0dcb0a98
// test 3 divisor 3, mean mode, sum of four
00000106 00000106 2 8 2
ffffffffffffffffffffffff
ffffffffffffffffffffffff
ffffffffffffffffffffffff
ffffffffffffffffffffffff
001002003004005006007008
010020030040050060070080
100200300400500600700800
800700600500400300200100
0 3ffc3ffc3ffc3ffc3ffc3ffc3ffc3ffc
1 09110922093309440955096609770988
// test 4 pack mode, four frames into three words
00000800 00000800 3 4 3
0123456789abcdef01234567
89abcdeffedcba9876543210
aaaabbbbccccddddeeeeffff
111122223333444455556666
0 765432100123456789abcdef01234567
1 ccccddddeeeeffff89abcdeffedcba98
2 111122223333444455556666aaaabbbb
// test 5 record of two, frames keep coming
00000000 00000000 2 5 2
123456789abcdef012345678
876543210fedcba987654321
555555555555555555555555
666666666666666666666666
777777777777777777777777
0 0123045607890abc0def001203450678
1 0876054302100fed0cba098706540321
// test 6 settings changed after state reset, capture keeps divisor 0
00000000 00000906 3 3 3
abcabcabcabcabcabcabcabc
001002003004005006007008
fff000fff000fff000fff000
0 0abc0abc0abc0abc0abc0abc0abc0abc
1 00010002000300040005000600070008
2 0fff00000fff00000fff00000fff0000

/* verilog.f */
verilog/adc_capture_pkg.sv
verilog/capture_settings.sv
verilog/frame_decimator.sv
verilog/ram_word_packer.sv
verilog/adc_capture_top.sv
bench/tb_adc_capture.sv

/* Bender.yml */
package:
  name: adc_capture

sources:
  - verilog/adc_capture_pkg.sv
  - verilog/capture_settings.sv
  - verilog/frame_decimator.sv
  - verilog/ram_word_packer.sv
  - verilog/adc_capture_top.sv
  - target: test
    files:
      - bench/tb_adc_capture.sv

/* bench/tb_adc_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_adc_capture;

	localparam int addr_bits = adc_capture_pkg::default_addr_bits;
	localparam int data_words = 256;
	localparam int max_writes = 64;
	localparam int wait_limit = 500;	// cycles per wait loop

	logic adc_clkinp;
	logic ADC_RESET;
	logic [31:0] settings;
	logic state_reset;
	logic trig;
	logic [addr_bits-1:0] rec_length;
	adc_capture_pkg::sample_frame_t frame;
	logic frame_valid;
	wire wr_en;
	wire [addr_bits-1:0] wr_addr;
	wire adc_capture_pkg::ram_word_t wr_data;
	wire busy;
	wire rcv_irq;

	logic [127:0] testdata [0:data_words-1];
	logic [addr_bits-1:0] got_addr [0:max_writes-1];
	logic [127:0] got_data [0:max_writes-1];
	int got_count;
	int ptr;
	int num_tests;
	int test_num;
	int tests_run;
	int error_count;
	int check_count;
	integer seed;
	logic timed_out;

	adc_capture_top uut
	(
		.adc_clkinp(adc_clkinp),
		.ADC_RESET(ADC_RESET),
		.settings(settings),
		.state_reset(state_reset),
		.trig(trig),
		.rec_length(rec_length),
		.frame(frame),
		.frame_valid(frame_valid),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.busy(busy),
		.rcv_irq(rcv_irq)
	);

	initial adc_clkinp = 1'b0;
	always #2 adc_clkinp = ~adc_clkinp;

	// every write seen on the ram port
	always @(negedge adc_clkinp)
	begin
		if (wr_en === 1'b1)
		begin
			if (got_count < max_writes)
			begin
				got_addr[got_count] = wr_addr;
				got_data[got_count] = wr_data;
			end
			got_count = got_count + 1;
		end
	end

	task automatic check_value
	(
		input string name,
		input logic [127:0] got,
		input logic [127:0] expected
	);
		check_count = check_count + 1;
		if (got !== expected)
		begin
			$display("MISMATCH %s: got %h, expected %h", name, got, expected);
			error_count = error_count + 1;
		end
	endtask

	task automatic wait_for_busy(input logic level, input int test_id);
		int n;
		n = 0;
		@(negedge adc_clkinp);
		while (busy !== level && n < wait_limit)
		begin
			@(negedge adc_clkinp);
			n = n + 1;
		end
		if (busy !== level)
		begin
			$display("timeout in test %0d, busy did not go to %0d within %0d cycles",
				test_id, level, wait_limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test(input int test_id);
		logic [31:0] load_settings;
		logic [31:0] late_settings;
		int frame_count;
		int write_count;
		int gap;
		int start_errors;
		int i;

		load_settings = testdata[ptr][31:0];
		late_settings = testdata[ptr+1][31:0];
		frame_count = testdata[ptr+3][31:0];
		write_count = testdata[ptr+4][31:0];
		start_errors = error_count;

		@(posedge adc_clkinp);
		settings <= load_settings;
		rec_length <= testdata[ptr+2][addr_bits-1:0];
		state_reset <= 1'b1;
		repeat (2) @(posedge adc_clkinp);
		state_reset <= 1'b0;
		settings <= late_settings;	// cfg must hold the loaded value
		got_count = 0;
		ptr = ptr + 5;
		@(negedge adc_clkinp);
		check_value("rcv_irq after state reset", rcv_irq, 1'b0);

		@(posedge adc_clkinp);
		trig <= 1'b1;
		@(posedge adc_clkinp);
		trig <= 1'b0;
		wait_for_busy(1'b1, test_id);
		if (!timed_out)
		begin
			for (i = 0; i < frame_count; i++)
			begin
				gap = $random(seed) & 3;
				repeat (gap)
				begin
					@(posedge adc_clkinp);
					frame_valid <= 1'b0;
				end
				@(posedge adc_clkinp);
				frame <= testdata[ptr+i][95:0];
				frame_valid <= 1'b1;
			end
			@(posedge adc_clkinp);
			frame_valid <= 1'b0;
			ptr = ptr + frame_count;

			wait_for_busy(1'b0, test_id);	// end of record
		end
		if (!timed_out)
		begin
			check_value("write count", got_count, write_count);
			for (i = 0; i < write_count; i++)
			begin
				if (i < got_count && i < max_writes)
				begin
					check_value("wr_addr", got_addr[i], testdata[ptr+2*i]);
					check_value("wr_data", got_data[i], testdata[ptr+2*i+1]);
				end
			end
			ptr = ptr + 2 * write_count;
			check_value("rcv_irq at record end", rcv_irq, 1'b1);

			// sticky irq blocks a new capture
			@(posedge adc_clkinp);
			trig <= 1'b1;
			@(posedge adc_clkinp);
			trig <= 1'b0;
			@(negedge adc_clkinp);
			check_value("busy after retrigger", busy, 1'b0);
			check_value("rcv_irq after retrigger", rcv_irq, 1'b1);

			tests_run = tests_run + 1;
			$display("test %0d finished, %0d writes, %0d errors", test_id, got_count,
				error_count - start_errors);
		end
	endtask

	initial
	begin
		ADC_RESET = 1'b1;
		settings = '0;
		state_reset = 1'b0;
		trig = 1'b0;
		rec_length = '0;
		frame = '0;
		frame_valid = 1'b0;
		got_count = 0;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		timed_out = 1'b0;
		seed = 32'h44b7_f7b7;
		$readmemh("bench/adc_capture_testdata.txt", testdata);

		repeat (3) @(posedge adc_clkinp);
		ADC_RESET <= 1'b0;
		@(negedge adc_clkinp);
		check_value("wr_en after reset", wr_en, 1'b0);
		check_value("busy after reset", busy, 1'b0);
		check_value("rcv_irq after reset", rcv_irq, 1'b0);

		if (^testdata[0] === 1'bx)
		begin
			$display("test data file could not be read");
			error_count = error_count + 1;
		end
		else
		begin
			num_tests = testdata[0][31:0];
			ptr = 1;
			test_num = 1;
			while (test_num <= num_tests && !timed_out)
			begin
				run_test(test_num);
				test_num = test_num + 1;
			end
		end

		$display("%0d tests run, %0d checks, %0d errors", tests_run, check_count, error_count);
		if (error_count == 0 && !timed_out)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/adc_capture_top.sv */
`timescale 1ns/100ps
`default_nettype none

module adc_capture_top
#(
	parameter int addr_bits = adc_capture_pkg::default_addr_bits
)
(
	input wire adc_clkinp,
	input wire ADC_RESET,
	input wire [31:0] settings,
	input wire state_reset,
	input wire trig,
	input wire [addr_bits-1:0] rec_length,
	input wire adc_capture_pkg::sample_frame_t frame,
	input wire frame_valid,
	output wire wr_en,
	output wire [addr_bits-1:0] wr_addr,
	output wire adc_capture_pkg::ram_word_t wr_data,
	output wire busy,
	output wire rcv_irq
);

	wire adc_capture_pkg::capture_cfg_t cfg;
	wire adc_capture_pkg::ram_word_t dec_word;
	wire dec_valid;
	wire capture_active;	// clears decimator group state

	capture_settings settings_stage
	(
		.adc_clkinp(adc_clkinp),
		.ADC_RESET(ADC_RESET),
		.state_reset(state_reset),
		.settings(settings),
		.cfg(cfg)
	);

	frame_decimator decimate_stage
	(
		.adc_clkinp(adc_clkinp),
		.ADC_RESET(ADC_RESET),
		.cfg(cfg),
		.capture_active(capture_active),
		.frame(frame),
		.frame_valid(frame_valid),
		.dec_word(dec_word),
		.dec_valid(dec_valid)
	);

	ram_word_packer
	#(
		.addr_bits(addr_bits)
	)
	packer_stage
	(
		.adc_clkinp(adc_clkinp),
		.ADC_RESET(ADC_RESET),
		.state_reset(state_reset),
		.cfg(cfg),
		.trig(trig),
		.rec_length(rec_length),
		.dec_word(dec_word),
		.dec_valid(dec_valid),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.busy(busy),
		.capture_active(capture_active),
		.rcv_irq(rcv_irq)
	);

endmodule

`default_nettype wire

/* verilog/ram_word_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module ram_word_packer
#(
	parameter int addr_bits = adc_capture_pkg::default_addr_bits
)
(
	input wire adc_clkinp,
	input wire ADC_RESET,
	input wire state_reset,
	input wire adc_capture_pkg::capture_cfg_t cfg,
	input wire trig,
	input wire [addr_bits-1:0] rec_length,
	input wire adc_capture_pkg::ram_word_t dec_word,
	input wire dec_valid,
	output logic wr_en,
	output logic [addr_bits-1:0] wr_addr,
	output adc_capture_pkg::ram_word_t wr_data,
	output logic busy,
	output logic capture_active,
	output logic rcv_irq
);

	localparam int sample_bits = adc_capture_pkg::sample_bits;
	localparam int frame_bits = adc_capture_pkg::num_lanes * sample_bits;
	localparam int word_bits = adc_capture_pkg::ram_word_bits;
	localparam int tail = word_bits - frame_bits;	// 32 bits left over per frame

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_capture = 2'd1;
	localparam logic [1:0] st_done = 2'd2;

	logic [1:0] state;
	logic [1:0] phase;
	logic [addr_bits-1:0] addr;
	logic [frame_bits-1:0] carry;
	logic [frame_bits-1:0] chunk;
	logic [word_bits-1:0] packed_word;
	logic write_now;
	logic last_write;

	assign busy = (state == st_capture);
	assign capture_active = (state == st_capture);
	assign rcv_irq = (state == st_done);	// sticky until state reset

	assign write_now = !cfg.pack_mode || phase != 2'd0;
	assign last_write = wr_en && (wr_addr == rec_length - 1'b1);

	// low 12 bits of each lane with lane 0 first in the stream
	always_comb
	begin
		for (int i = 0; i < adc_capture_pkg::num_lanes; i++)
			chunk[i*sample_bits +: sample_bits] = dec_word[i][sample_bits-1:0];
	end

	// four frames give three words
	always_comb
	begin
		case (phase)
			2'd1: packed_word = {chunk[tail-1:0], carry};
			2'd2: packed_word = {chunk[2*tail-1:0], carry[frame_bits-tail-1:0]};
			default: packed_word = {chunk, carry[tail-1:0]};
		endcase
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET || state_reset)
		begin
			state <= st_idle;
			wr_en <= 1'b0;
			addr <= '0;
			phase <= 2'd0;
		end
		else
		begin
			wr_en <= 1'b0;
			case (state)
				st_idle:
				begin
					if (trig)
					begin
						state <= st_capture;
						addr <= '0;
						phase <= 2'd0;
					end
				end
				st_capture:
				begin
					if (last_write)
						state <= st_done;	// partial packed bits are dropped
					else if (dec_valid)
					begin
						if (write_now)
						begin
							wr_en <= 1'b1;
							addr <= addr + 1'b1;
						end
						if (cfg.pack_mode)
							phase <= phase + 2'd1;
					end
				end
				st_done:
					state <= st_done;	// trig ignored here
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (dec_valid)
		begin
			wr_addr <= addr;
			if (cfg.pack_mode)
				wr_data <= packed_word;
			else
				wr_data <= dec_word;
			carry <= chunk >> (tail * phase);	// bits not yet written
		end
	end

endmodule

`default_nettype wire

/* verilog/frame_decimator.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_decimator
(
	input wire adc_clkinp,
	input wire ADC_RESET,
	input wire adc_capture_pkg::capture_cfg_t cfg,
	input wire capture_active,
	input wire adc_capture_pkg::sample_frame_t frame,
	input wire frame_valid,
	output adc_capture_pkg::ram_word_t dec_word,
	output logic dec_valid
);

	localparam int pad_bits = adc_capture_pkg::lane_bits - adc_capture_pkg::sample_bits;

	logic [3:0] grp_cnt;
	logic grp_end;
	adc_capture_pkg::ram_word_t acc_next;

	assign grp_end = (grp_cnt == cfg.divisor);

	// first frame of a group always loads
	always_comb
	begin
		for (int i = 0; i < adc_capture_pkg::num_lanes; i++)
		begin
			if (cfg.mean_mode && grp_cnt != 4'd0)
				acc_next[i] = dec_word[i] + {{pad_bits{1'b0}}, frame.lane[i]};
			else
				acc_next[i] = {{pad_bits{1'b0}}, frame.lane[i]};
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET || !capture_active)
		begin
			grp_cnt <= 4'd0;
			dec_valid <= 1'b0;
		end
		else
		begin
			dec_valid <= frame_valid && grp_end;	// word complete next cycle
			if (frame_valid)
			begin
				if (grp_end)
					grp_cnt <= 4'd0;
				else
					grp_cnt <= grp_cnt + 4'd1;
			end
		end
	end

	// dec_word doubles as the per-lane accumulator
	always_ff @(posedge adc_clkinp)
	begin
		if (!capture_active)
			dec_word <= '0;
		else if (frame_valid)
			dec_word <= acc_next;
	end

endmodule

`default_nettype wire

/* verilog/capture_settings.sv */
`timescale 1ns/100ps
`default_nettype none

module capture_settings
(
	input wire adc_clkinp,
	input wire ADC_RESET,
	input wire state_reset,
	input wire [31:0] settings,
	output adc_capture_pkg::capture_cfg_t cfg
);

	// field positions in the host settings word
	localparam int div_lsb = 1;
	localparam int div_bits = 4;
	localparam int mean_bit = 8;
	localparam int pack_bit = 11;

	adc_capture_pkg::capture_cfg_t cfg_next;

	always_comb
	begin
		cfg_next.divisor = settings[div_lsb +: div_bits];
		cfg_next.mean_mode = settings[mean_bit];
		cfg_next.pack_mode = settings[pack_bit];
		cfg_next.spare = 2'b00;	// reads as zero
	end

	// only sampled under state reset so a running capture keeps its settings
	always_ff @(posedge adc_clkinp)
	begin
		if (ADC_RESET)
			cfg <= '0;
		else if (state_reset)
			cfg <= cfg_next;
	end

endmodule

`default_nettype wire

/* verilog/adc_capture_pkg.sv */
`default_nettype none

package adc_capture_pkg;

	localparam int num_lanes = 8;
	localparam int sample_bits = 12;	// adc sample width
	localparam int lane_bits = 16;	// room for a sum of 16 samples
	localparam int ram_word_bits = num_lanes * lane_bits;
	localparam int default_addr_bits = 15;

	// one adc frame with lane 0 in the low bits
	typedef struct packed {
		logic [num_lanes-1:0][sample_bits-1:0] lane;
	} sample_frame_t;

	// one external ram word
	typedef logic [num_lanes-1:0][lane_bits-1:0] ram_word_t;

	// latched acquisition settings
	typedef struct packed {
		logic [1:0] spare;
		logic pack_mode;	// 12 bit lane packing
		logic mean_mode;	// sum instead of keep-last
		logic [3:0] divisor;	// group is divisor+1 frames
	} capture_cfg_t;

endpackage

`default_nettype wire
